//--- src/adapt_params.svh
//--------------------
// Register map constants of the adapter configuration block.
// Included by the RTL and by the testbench reference model.
//--------------------
`ifndef ADAPT_PARAMS_SVH
`define ADAPT_PARAMS_SVH

//--------------------
// Byte offsets on the bus
//--------------------
`define ADAPT_RX0_OFF 8'h08 // RX config 0
`define ADAPT_RX1_OFF 8'h10 // RX config 1
`define ADAPT_TX0_OFF 8'h18 // TX config 0
`define ADAPT_TX1_OFF 8'h1C // TX config 1

//--------------------
// Implemented bits, all others read zero
//--------------------
`define ADAPT_RX0_MASK 32'h0F00000F // phcomp, clk_div, dbi, swap
`define ADAPT_RX1_MASK 32'h80001FFF // wa_mode, threshold, markers, fifo, wa_en
`define ADAPT_TX0_MASK 32'hF3FF0003 // phcomp, clk_div, wm, fifo, markers, dbi, swap
`define ADAPT_TX1_MASK 32'hC000C300 // sdr, pad, loopback, fwd clk test, bert bit

//--------------------
// Values loaded at reset
//--------------------
`define ADAPT_RX0_RST 32'h02000000
`define ADAPT_RX1_RST 32'h00000200
`define ADAPT_TX0_RST 32'h20000000
`define ADAPT_TX1_RST 32'h40000000 // Pad enable set

//--------------------
// Field positions and counts
//--------------------
`define ADAPT_RX1_STICKY_BIT 31 // Word alignment mode
`define ADAPT_TX_DIV_LSB     24 // TX0 divider field 25:24
`define ADAPT_RX_DIV_LSB     2  // RX0 divider field 3:2
`define ADAPT_SYNC_STAGES    2  // Ack synchroniser depth

`endif

//--- src/adapt_reg_pkg.sv
//--------------------
// Bus and register select types of the configuration block.
// Imported by every module that touches the register bus.
//--------------------
`default_nettype none

package adapt_reg_pkg;

  typedef logic [31:0] bus_word_t; // Data word
  typedef logic [7:0]  bus_addr_t; // Byte address
  typedef logic [3:0]  byte_en_t;  // One enable per lane

  // Decoded register target of a bus access
  typedef enum logic [2:0] {
    SEL_RX0,
    SEL_RX1,
    SEL_TX0,
    SEL_TX1,
    SEL_NONE // Unmapped offset
  } cfg_reg_sel_t;

endpackage

`default_nettype wire

//--- src/clk_div_pkg.sv
//--------------------
// Clock divider field and selection types.
//--------------------
`default_nettype none

package clk_div_pkg;

  // Encoded divider field as stored in TX0 and RX0
  typedef enum logic [1:0] {
    DIV_NONE = 2'b00,
    DIV_BY1  = 2'b01,
    DIV_BY2  = 2'b10,
    DIV_BY4  = 2'b11
  } div_code_t;

  // One-hot selection sent to the link clock domain
  typedef struct packed {
    logic div4;
    logic div2;
    logic div1;
  } div_sel_t;

endpackage

`default_nettype wire

//--- src/adapt_cfg_regs.sv
//--------------------
// Write side of the four adapter config registers.
// Stores enabled byte lanes through the implemented-bit masks.
//--------------------
`timescale 1ns/1ps
`default_nettype none

`include "adapt_params.svh"

module adapt_cfg_regs
  import adapt_reg_pkg::*;
(
  input  logic      clk,        // Bus clock
  input  logic      reset_n,    // Async reset, active low
  input  bus_addr_t address,    // Byte address
  input  bus_word_t writedata,  // Write data
  input  byte_en_t  byteenable, // Lane enables
  input  logic      write,      // Write strobe
  output bus_word_t rx_0,       // RX config 0
  output bus_word_t rx_1,       // RX config 1
  output bus_word_t tx_0,       // TX config 0
  output bus_word_t tx_1        // TX config 1
);

  cfg_reg_sel_t wr_sel; // Target of this write
  bus_word_t    rx1_wr; // RX1 next value with sticky bit

  // Merge enabled lanes of wdata into old_val, masked
  function automatic bus_word_t lane_write(
    input bus_word_t old_val,
    input bus_word_t wdata,
    input byte_en_t  be,
    input bus_word_t mask
  );
    bus_word_t res;
    int        i;
    res = old_val;
    for (i = 0; i < 4; i++)
    begin
      if (be[i])
      begin
        res[8*i +: 8] = wdata[8*i +: 8] & mask[8*i +: 8];
      end
    end
    return res;
  endfunction

  //--------------------
  // Address decode
  //--------------------
  always_comb
  begin
    case (address)
      `ADAPT_RX0_OFF: wr_sel = SEL_RX0;
      `ADAPT_RX1_OFF: wr_sel = SEL_RX1;
      `ADAPT_TX0_OFF: wr_sel = SEL_TX0;
      `ADAPT_TX1_OFF: wr_sel = SEL_TX1;
      default:        wr_sel = SEL_NONE; // Old BERT space too
    endcase
  end

  // Alignment mode can only be set, reset clears it
  always_comb
  begin
    rx1_wr = lane_write(rx_1, writedata, byteenable, `ADAPT_RX1_MASK);
    if (rx_1[`ADAPT_RX1_STICKY_BIT])
    begin
      rx1_wr[`ADAPT_RX1_STICKY_BIT] = 1'b1; // Already set, hold
    end
  end

  //--------------------
  // Storage
  //--------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      rx_0 <= `ADAPT_RX0_RST;
      rx_1 <= `ADAPT_RX1_RST;
      tx_0 <= `ADAPT_TX0_RST;
      tx_1 <= `ADAPT_TX1_RST;
    end
    else if (write)
    begin
      case (wr_sel)
        SEL_RX0: rx_0 <= lane_write(rx_0, writedata, byteenable, `ADAPT_RX0_MASK);
        SEL_RX1: rx_1 <= rx1_wr;
        SEL_TX0: tx_0 <= lane_write(tx_0, writedata, byteenable, `ADAPT_TX0_MASK);
        SEL_TX1: tx_1 <= lane_write(tx_1, writedata, byteenable, `ADAPT_TX1_MASK);
        default: ; // Unmapped, nothing stored
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/adapt_read_mux.sv
//--------------------
// Read side of the config block. Data appears one cycle after
// the read is sampled, zero for unmapped offsets or no read.
//--------------------
`timescale 1ns/1ps
`default_nettype none

`include "adapt_params.svh"

module adapt_read_mux
  import adapt_reg_pkg::*;
(
  input  logic      clk,      // Bus clock
  input  logic      reset_n,  // Async reset, active low
  input  bus_addr_t address,  // Byte address
  input  logic      read,     // Read level
  input  bus_word_t rx_0,     // RX config 0
  input  bus_word_t rx_1,     // RX config 1
  input  bus_word_t tx_0,     // TX config 0
  input  bus_word_t tx_1,     // TX config 1
  output bus_word_t readdata  // Registered read data
);

  bus_word_t rdata_comb; // Selected word before the flop

  always_comb
  begin
    rdata_comb = '0;
    if (read)
    begin
      case (address)
        `ADAPT_RX0_OFF: rdata_comb = rx_0;
        `ADAPT_RX1_OFF: rdata_comb = rx_1;
        `ADAPT_TX0_OFF: rdata_comb = tx_0;
        `ADAPT_TX1_OFF: rdata_comb = tx_1;
        default:        rdata_comb = '0; // Unmapped reads zero
      endcase
    end
  end

  // Read data register
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      readdata <= '0;
    end
    else
    begin
      readdata <= rdata_comb;
    end
  end

endmodule

`default_nettype wire

//--- src/clk_div_loader.sv
//--------------------
// Passes one divider selection to the link clock domain.
// Toggle load out, ack comes back and is resynchronised here.
//--------------------
`timescale 1ns/1ps
`default_nettype none

`include "adapt_params.svh"

module clk_div_loader
  import clk_div_pkg::*;
(
  input  logic      clk,      // Bus clock
  input  logic      reset_n,  // Async reset, active low
  input  div_code_t div_code, // Field from the config register
  input  logic      ld_ack,   // Ack level from other domain
  output logic      ld,       // Toggle load
  output div_sel_t  div_sel   // Held one-hot selection
);

  logic [`ADAPT_SYNC_STAGES-1:0] ack_sync; // Ack synchroniser chain
  div_sel_t                      dec_sel;  // Decoded field
  logic                          busy;     // Load still in flight
  logic                          update;   // Launch a new load

  //--------------------
  // Field decode
  //--------------------
  always_comb
  begin
    dec_sel = '0;
    case (div_code)
      DIV_BY1: dec_sel.div1 = 1'b1;
      DIV_BY2: dec_sel.div2 = 1'b1;
      DIV_BY4: dec_sel.div4 = 1'b1;
      default: dec_sel      = '0; // DIV_NONE, nothing selected
    endcase
  end

  // Ack resync, oldest stage at the top
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      ack_sync <= '0;
    end
    else
    begin
      ack_sync <= {ack_sync[`ADAPT_SYNC_STAGES-2:0], ld_ack};
    end
  end

  assign busy   = ld ^ ack_sync[`ADAPT_SYNC_STAGES-1]; // Ack not back yet
  assign update = !busy && (dec_sel != div_sel);         // Pending change held while busy

  //--------------------
  // Load toggle and selection capture
  //--------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      ld      <= 1'b0;
      div_sel <= '0;
    end
    else if (update)
    begin
      ld      <= ~ld;    // One toggle per change
      div_sel <= dec_sel; // Same edge as the toggle
    end
  end

endmodule

`default_nettype wire

//--- src/adapt_reg_top.sv
//--------------------
// Adapter configuration block top. Bus registers, read path and
// the TX and RX clock divider loaders.
//--------------------
`timescale 1ns/1ps
`default_nettype none

`include "adapt_params.svh"

module adapt_reg_top
  import adapt_reg_pkg::*;
  import clk_div_pkg::*;
(
  input  logic      clk,               // Bus clock
  input  logic      reset_n,           // Async reset, active low
  input  bus_addr_t address,           // Byte address
  input  bus_word_t writedata,         // Write data
  input  byte_en_t  byteenable,        // Lane enables
  input  logic      read,              // Read level
  input  logic      write,             // Write strobe
  input  logic      tx_clk_div_ld_ack, // TX divider ack
  input  logic      rx_clk_div_ld_ack, // RX divider ack
  output bus_word_t readdata,          // Read data, one cycle late
  output bus_word_t rx_0,              // RX config 0
  output bus_word_t rx_1,              // RX config 1
  output bus_word_t tx_0,              // TX config 0
  output bus_word_t tx_1,              // TX config 1
  output logic      tx_clk_div_ld,     // TX divider load toggle
  output logic      tx_clk_div_1,      // TX divide by 1
  output logic      tx_clk_div_2,      // TX divide by 2
  output logic      tx_clk_div_4,      // TX divide by 4
  output logic      rx_clk_div_ld,     // RX divider load toggle
  output logic      rx_clk_div_1,      // RX divide by 1
  output logic      rx_clk_div_2,      // RX divide by 2
  output logic      rx_clk_div_4       // RX divide by 4
);

  div_sel_t tx_sel; // TX one-hot from loader
  div_sel_t rx_sel; // RX one-hot from loader

  adapt_cfg_regs u_cfg_regs (
    .clk        (clk),
    .reset_n    (reset_n),
    .address    (address),
    .writedata  (writedata),
    .byteenable (byteenable),
    .write      (write),
    .rx_0       (rx_0),
    .rx_1       (rx_1),
    .tx_0       (tx_0),
    .tx_1       (tx_1)
  );

  adapt_read_mux u_read_mux (
    .clk      (clk),
    .reset_n  (reset_n),
    .address  (address),
    .read     (read),
    .rx_0     (rx_0),
    .rx_1     (rx_1),
    .tx_0     (tx_0),
    .tx_1     (tx_1),
    .readdata (readdata)
  );

  //--------------------
  // Divider loaders
  //--------------------
  clk_div_loader u_tx_div (
    .clk      (clk),
    .reset_n  (reset_n),
    .div_code (div_code_t'(tx_0[`ADAPT_TX_DIV_LSB +: $bits(div_code_t)])), // TX0 25:24
    .ld_ack   (tx_clk_div_ld_ack),
    .ld       (tx_clk_div_ld),
    .div_sel  (tx_sel)
  );

  clk_div_loader u_rx_div (
    .clk      (clk),
    .reset_n  (reset_n),
    .div_code (div_code_t'(rx_0[`ADAPT_RX_DIV_LSB +: $bits(div_code_t)])), // RX0 3:2
    .ld_ack   (rx_clk_div_ld_ack),
    .ld       (rx_clk_div_ld),
    .div_sel  (rx_sel)
  );

  assign tx_clk_div_1 = tx_sel.div1;
  assign tx_clk_div_2 = tx_sel.div2;
  assign tx_clk_div_4 = tx_sel.div4;
  assign rx_clk_div_1 = rx_sel.div1;
  assign rx_clk_div_2 = rx_sel.div2;
  assign rx_clk_div_4 = rx_sel.div4;

endmodule

`default_nettype wire

//--- tests/adapt_reg_assertions.sv
//--------------------
// Concurrent checks on each divider loader, attached by bind.
// Covers the one-hot selection and the load toggle rules.
//--------------------
`timescale 1ns/1ps
`default_nettype none

`include "adapt_params.svh"

module adapt_reg_assertions
  import clk_div_pkg::*;
(
  input logic     clk,     // Bus clock
  input logic     reset_n, // Async reset, active low
  input logic     ld,      // Toggle load
  input logic     ld_ack,  // Raw ack from other domain
  input div_sel_t div_sel  // Held selection
);

  int fails = 0; // Failed assertions so far

  // Never more than one divide ratio
  sel_onehot: assert property (
    @(posedge clk) disable iff (!reset_n) $onehot0(div_sel)
  ) else
  begin
    $error("divider selection has more than one bit set");
    fails++;
  end

  // New load only once the resynchronised ack matches the load
  ld_not_busy: assert property (
    @(posedge clk) disable iff (!reset_n)
      (ld != $past(ld)) |-> ($past(ld) == $past(ld_ack, `ADAPT_SYNC_STAGES + 1))
  ) else
  begin
    $error("divider load toggled while busy");
    fails++;
  end

  // Selection moves together with the load
  sel_with_ld: assert property (
    @(posedge clk) disable iff (!reset_n) (div_sel != $past(div_sel)) |-> (ld != $past(ld))
  ) else
  begin
    $error("divider selection changed without a load toggle");
    fails++;
  end

endmodule

bind clk_div_loader adapt_reg_assertions u_loader_assert (
  .clk     (clk),
  .reset_n (reset_n),
  .ld      (ld),
  .ld_ack  (ld_ack),
  .div_sel (div_sel)
);

`default_nettype wire

//--- tests/adapt_reg_checker.sv
//--------------------
// Watches the DUT bus and config outputs. Keeps a register model
// and compares at every falling edge, counts errors per test.
//--------------------
`timescale 1ns/1ps
`default_nettype none

`include "adapt_params.svh"

module adapt_reg_checker
  import adapt_reg_pkg::*;
(
  input  logic      clk,        // Bus clock
  input  logic      reset_n,    // Async reset, active low
  input  bus_addr_t address,    // Bus address as driven
  input  bus_word_t writedata,  // Write data as driven
  input  byte_en_t  byteenable, // Lane enables as driven
  input  logic      read,       // Read level
  input  logic      write,      // Write strobe
  input  bus_word_t readdata,   // DUT read data
  input  bus_word_t rx_0,       // DUT config outputs
  input  bus_word_t rx_1,
  input  bus_word_t tx_0,
  input  bus_word_t tx_1,
  output int        errors,     // Failed checks so far
  output int        checks      // Checks done so far
);

  bus_word_t model [4];   // RX0, RX1, TX0, TX1
  bus_word_t exp_rd;      // Expected readdata after this edge
  logic      armed = 0;   // Edge after reset seen
  int        idx;         // Model index of the bus address
  int        test_no = 0; // Finished tests
  int        err_base = 0; // Errors at start of test

  initial
  begin
    errors = 0;
    checks = 0;
  end

  // Offset to model slot, -1 when unmapped
  function automatic int index_of(input bus_addr_t addr);
    case (addr)
      `ADAPT_RX0_OFF: return 0;
      `ADAPT_RX1_OFF: return 1;
      `ADAPT_TX0_OFF: return 2;
      `ADAPT_TX1_OFF: return 3;
      default:        return -1;
    endcase
  endfunction

  function automatic bus_word_t mask_of(input int slot);
    case (slot)
      0:       return `ADAPT_RX0_MASK;
      1:       return `ADAPT_RX1_MASK;
      2:       return `ADAPT_TX0_MASK;
      default: return `ADAPT_TX1_MASK;
    endcase
  endfunction

  // Reference write, bit by bit from its lane enable
  function automatic bus_word_t ref_write(input int slot, input bus_word_t old,
                                          input bus_word_t wdata, input byte_en_t be);
    bus_word_t res;
    bus_word_t mask;
    res  = old;
    mask = mask_of(slot);
    for (int b = 0; b < 32; b++)
    begin
      if (be[b / 8])
      begin
        res[b] = wdata[b] & mask[b];
      end
    end
    if (slot == 1 && old[`ADAPT_RX1_STICKY_BIT])
    begin
      res[`ADAPT_RX1_STICKY_BIT] = 1'b1; // Set once, kept till reset
    end
    return res;
  endfunction

  task automatic compare_word(input string what, input bus_word_t got, input bus_word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  task automatic end_test(input string name);
    test_no++;
    $display("test %0d %s done with %0d errors", test_no, name, errors - err_base);
    err_base = errors;
  endtask

  task automatic print_counts();
    $display("%0d tests, %0d checks, %0d errors", test_no, checks, errors);
  endtask

  //--------------------
  // Model update at the bus edge
  //--------------------
  always @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      model[0] = `ADAPT_RX0_RST;
      model[1] = `ADAPT_RX1_RST;
      model[2] = `ADAPT_TX0_RST;
      model[3] = `ADAPT_TX1_RST;
      exp_rd   = '0;
      armed    = 1'b0;
    end
    else
    begin
      idx    = index_of(address);
      exp_rd = (read && idx >= 0) ? model[idx] : '0; // Old value, read before write
      if (write && idx >= 0)
      begin
        model[idx] = ref_write(idx, model[idx], writedata, byteenable);
      end
      armed = 1'b1;
    end
  end

  //--------------------
  // Comparison, outputs settled
  //--------------------
  always @(negedge clk)
  begin
    if (reset_n && armed)
    begin
      compare_word("readdata", readdata, exp_rd);
      compare_word("rx_0", rx_0, model[0]);
      compare_word("rx_1", rx_1, model[1]);
      compare_word("tx_0", tx_0, model[2]);
      compare_word("tx_1", tx_1, model[3]);
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_adapt_reg.sv
//--------------------
// Testbench top for the adapter config block. Drives the bus,
// echoes divider loads back as acks and sequences the tests.
//--------------------
`timescale 1ns/1ps
`default_nettype none

`include "adapt_params.svh"

module tb_adapt_reg
  import adapt_reg_pkg::*;
();

  logic      clk;
  logic      reset_n;
  bus_addr_t address;
  bus_word_t writedata;
  byte_en_t  byteenable;
  logic      read;
  logic      write;
  bus_word_t readdata;
  bus_word_t rx_0, rx_1, tx_0, tx_1;
  logic      tx_clk_div_ld, tx_clk_div_1, tx_clk_div_2, tx_clk_div_4;
  logic      rx_clk_div_ld, rx_clk_div_1, rx_clk_div_2, rx_clk_div_4;
  logic [1:0]      echo_ack;     // Acks to DUT, index 0 is TX
  logic [1:0]      ld_vec;       // Loads from DUT
  logic [1:0]      ld_prev = '0; // Loads at last edge
  logic [1:0][2:0] sel_vec;      // {div4, div2, div1} per direction
  logic            ack_hold;     // Withhold acks
  logic [15:0]     stim_lfsr;    // Stimulus random state
  logic [15:0]     echo_lfsr;    // Ack delay random state
  logic [2:0]      echo_d;       // Raw delay bits
  int              echo_cnt [2] = '{0, 0};
  int              tog_cnt [2] = '{0, 0}; // Load toggles seen
  int              chk_errors, chk_checks;
  int              assert_fails; // Bound assertion failures, both loaders
  logic [31:0]     r_idx, r_data, r_be;
  int              base;
  bit              ok;

  assign ld_vec  = {rx_clk_div_ld, tx_clk_div_ld};
  assign sel_vec = {{rx_clk_div_4, rx_clk_div_2, rx_clk_div_1},
                    {tx_clk_div_4, tx_clk_div_2, tx_clk_div_1}};

  adapt_reg_top DUT (
    .clk (clk), .reset_n (reset_n), .address (address), .writedata (writedata),
    .byteenable (byteenable), .read (read), .write (write),
    .tx_clk_div_ld_ack (echo_ack[0]), .rx_clk_div_ld_ack (echo_ack[1]),
    .readdata (readdata), .rx_0 (rx_0), .rx_1 (rx_1), .tx_0 (tx_0), .tx_1 (tx_1),
    .tx_clk_div_ld (tx_clk_div_ld), .tx_clk_div_1 (tx_clk_div_1),
    .tx_clk_div_2 (tx_clk_div_2), .tx_clk_div_4 (tx_clk_div_4),
    .rx_clk_div_ld (rx_clk_div_ld), .rx_clk_div_1 (rx_clk_div_1),
    .rx_clk_div_2 (rx_clk_div_2), .rx_clk_div_4 (rx_clk_div_4)
  );

  adapt_reg_checker u_chk (
    .clk (clk), .reset_n (reset_n), .address (address), .writedata (writedata),
    .byteenable (byteenable), .read (read), .write (write), .readdata (readdata),
    .rx_0 (rx_0), .rx_1 (rx_1), .tx_0 (tx_0), .tx_1 (tx_1),
    .errors (chk_errors), .checks (chk_checks)
  );

  always #2 clk = ~clk; // 4 ns period

  // Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val       = {val[30:0], stim_lfsr[0]};
      stim_lfsr = lfsr_next(stim_lfsr);
    end
  endtask

  function automatic bus_addr_t offset_of(input logic [1:0] slot);
    case (slot)
      2'd0:    return `ADAPT_RX0_OFF;
      2'd1:    return `ADAPT_RX1_OFF;
      2'd2:    return `ADAPT_TX0_OFF;
      default: return `ADAPT_TX1_OFF;
    endcase
  endfunction

  // Divider code to {div4, div2, div1}
  function automatic logic [2:0] onehot_of(input logic [1:0] code);
    case (code)
      2'b01:   return 3'b001;
      2'b10:   return 3'b010;
      2'b11:   return 3'b100;
      default: return 3'b000;
    endcase
  endfunction

  //--------------------
  // Bus tasks
  //--------------------
  task automatic bus_write(input bus_addr_t addr, input bus_word_t data, input byte_en_t be);
    @(posedge clk);
    address    <= addr;
    writedata  <= data;
    byteenable <= be;
    write      <= 1'b1;
    @(posedge clk);
    write      <= 1'b0;
  endtask

  task automatic bus_read(input bus_addr_t addr);
    @(posedge clk);
    address <= addr;
    read    <= 1'b1;
    @(posedge clk);
    read    <= 1'b0;
  endtask

  // Until selection matches and the ack is home
  task automatic wait_div_done(input int dir, input logic [2:0] exp, output bit done);
    done = 1'b0;
    for (int n = 0; n < 100 && !done; n++)
    begin
      @(negedge clk);
      done = (sel_vec[dir] == exp) && (echo_ack[dir] == ld_vec[dir]);
    end
  endtask

  task automatic load_divider(input int dir, input logic [1:0] code, input bit count_it);
    int  start;
    bit  done;
    start = tog_cnt[dir];
    if (dir == 0)
    begin
      bus_write(`ADAPT_TX0_OFF, {6'b0, code, 24'h0}, 4'b1000);
    end
    else
    begin
      bus_write(`ADAPT_RX0_OFF, {28'h0, code, 2'b00}, 4'b0001);
    end
    wait_div_done(dir, onehot_of(code), done);
    if (!done)
    begin
      u_chk.report_failure("divider selection or ack did not settle in time");
    end
    else if (count_it)
    begin
      u_chk.compare_word("load toggles per change", tog_cnt[dir] - start, 1);
    end
  endtask

  //--------------------
  // Ack echo and toggle count
  //--------------------
  always @(posedge clk)
  begin
    for (int k = 0; k < 2; k++)
    begin
      if (reset_n && ld_vec[k] != ld_prev[k])
      begin
        tog_cnt[k] = tog_cnt[k] + 1;
      end
      if (reset_n && !ack_hold && echo_cnt[k] > 0)
      begin
        echo_cnt[k] = echo_cnt[k] - 1;
        if (echo_cnt[k] == 0)
        begin
          echo_ack[k] <= ld_vec[k]; // Other domain took it
        end
      end
      else if (reset_n && !ack_hold && ld_vec[k] != echo_ack[k])
      begin
        for (int i = 0; i < 3; i++)
        begin
          echo_d    = {echo_d[1:0], echo_lfsr[0]};
          echo_lfsr = lfsr_next(echo_lfsr);
        end
        echo_cnt[k] = 3 + echo_d; // 3 to 10 cycles
      end
    end
    ld_prev = ld_vec;
  end

  //--------------------
  // Test sequence
  //--------------------
  initial
  begin
    clk        = 1'b0;
    reset_n    = 1'b0;
    address    = '0;
    writedata  = '0;
    byteenable = '0;
    read       = 1'b0;
    write      = 1'b0;
    echo_ack   = '0;
    ack_hold   = 1'b0;
    echo_d     = '0;
    stim_lfsr  = 16'd21201;
    echo_lfsr  = 16'd21201;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;

    for (int s = 0; s < 4; s++)
    begin
      bus_read(offset_of(s[1:0]));
    end
    @(negedge clk);
    u_chk.compare_word("divider outputs after reset", {ld_vec, sel_vec}, '0);
    u_chk.end_test("reset values");

    for (int n = 0; n < 40; n++)
    begin
      take_bits(2, r_idx);
      take_bits(32, r_data);
      take_bits(4, r_be);
      bus_write(offset_of(r_idx[1:0]), r_data, r_be[3:0]);
      bus_read(offset_of(r_idx[1:0]));
    end
    u_chk.end_test("random lane writes");

    bus_write(`ADAPT_RX1_OFF, 32'h8000_0000, 4'hF);
    bus_write(`ADAPT_RX1_OFF, 32'h0000_0ABC, 4'hF);
    bus_read(`ADAPT_RX1_OFF);
    @(negedge clk);
    u_chk.compare_word("rx_1 after sticky clear attempt", rx_1, 32'h8000_0ABC);
    u_chk.end_test("sticky alignment bit");

    bus_read(8'h00);
    bus_read(8'h04);
    bus_read(8'h0C);
    bus_read(8'h14);
    for (int a = 8'h20; a <= 8'h3C; a += 4)
    begin
      bus_read(a[7:0]);
    end
    bus_read(8'hFF);
    @(posedge clk);
    address <= `ADAPT_TX1_OFF; // Mapped, but no read
    repeat (3) @(posedge clk);
    u_chk.end_test("unmapped and idle reads");

    for (int dir = 0; dir < 2; dir++)
    begin
      load_divider(dir, 2'b00, 1'b0); // Start from idle
      load_divider(dir, 2'b01, 1'b1);
      load_divider(dir, 2'b10, 1'b1);
      load_divider(dir, 2'b11, 1'b1);
      load_divider(dir, 2'b00, 1'b1);
    end
    u_chk.end_test("divider loads");

    ack_hold = 1'b1;
    base     = tog_cnt[0];
    bus_write(`ADAPT_TX0_OFF, 32'h0300_0000, 4'b1000);
    ok = 1'b0;
    for (int n = 0; n < 20 && !ok; n++)
    begin
      @(negedge clk);
      ok = (tog_cnt[0] - base) >= 1;
    end
    if (!ok)
    begin
      u_chk.report_failure("first TX divider load never toggled");
    end
    bus_write(`ADAPT_TX0_OFF, 32'h0200_0000, 4'b1000);
    repeat (15) @(negedge clk);
    u_chk.compare_word("toggles while ack withheld", tog_cnt[0] - base, 1);
    ack_hold = 1'b0;
    wait_div_done(0, 3'b010, ok);
    if (!ok)
    begin
      u_chk.report_failure("held TX divider change was not applied after the ack");
    end
    u_chk.compare_word("toggles after ack returned", tog_cnt[0] - base, 2);
    u_chk.end_test("back-pressure");

    u_chk.print_counts();
    assert_fails = DUT.u_tx_div.u_loader_assert.fails
                 + DUT.u_rx_div.u_loader_assert.fails;
    if (chk_errors == 0 && chk_checks > 0 && assert_fails == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+src
src/adapt_reg_pkg.sv
src/clk_div_pkg.sv
src/adapt_cfg_regs.sv
src/adapt_read_mux.sv
src/clk_div_loader.sv
src/adapt_reg_top.sv
tests/adapt_reg_assertions.sv
tests/adapt_reg_checker.sv
tests/tb_adapt_reg.sv
